// ==== all.f ====
+incdir+dv
source/lz77_pkg.sv
source/lz77_win_if.sv
source/lz77_fetch.sv
source/lz77_window.sv
source/lz77_search.sv
source/lz77_top.sv
dv/lz77_tb.sv

// ==== dv/lz77_tb_model.svh ====
/*
  Greedy LZ77 reference model and random byte source for the testbench.
  Included inside the testbench module. It reads job_bytes and fills the
  expected token arrays, one token per greedy step.
*/

`ifndef LZ77_TB_MODEL_SVH
`define LZ77_TB_MODEL_SVH

// 32-bit linear congruential step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1103515245 + 32'd12345;
endfunction

// one greedy token at byte position p of an n-byte job
function automatic void model_token(input int p, input int n,
                                    output bit lit, output int len, output int dst);
  int cap;
  int lim;
  int run;
  int best_len;
  int best_dst;
  cap      = (n - p < LEN_MAX) ? n - p : LEN_MAX;
  lim      = (p < WIN_SIZE) ? p : WIN_SIZE;
  best_len = 0;
  best_dst = 0;
  // source lies wholly in the window, so the run stops at d
  for (int d = 1; d <= lim; d++) begin
    run = 0;
    while (run < cap && run < d && job_bytes[p - d + run] == job_bytes[p + run]) begin
      run++;
    end
    // strict compare keeps the nearest distance on a tie
    if (run > best_len) begin
      best_len = run;
      best_dst = d;
    end
  end
  if (best_len < lz77_pkg::SIZE_LEN_MIN) begin
    lit = 1'b1;
    len = 1;
    dst = 0;
  end else begin
    lit = 1'b0;
    len = best_len;
    dst = best_dst;
  end
endfunction

// expected token list of the whole job, returns the token count
function automatic int build_expected(input int n);
  int p;
  int k;
  bit lit;
  int len;
  int dst;
  p = 0;
  k = 0;
  while (p < n) begin
    model_token(p, n, lit, len, dst);
    exp_lit_a[k]  = lit;
    exp_len_a[k]  = len;
    exp_dst_a[k]  = dst;
    exp_byte_a[k] = job_bytes[p];
    p += len;
    k++;
  end
  return k;
endfunction

`endif

// ==== dv/lz77_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

/*
  Testbench for the LZ77 match finder.
  Runs four jobs through lz77_top with a FIFO model on the read port:
  random bytes, the same random bytes again, one repeated byte, then
  distinct bytes. Concurrent assertions compare every token with the
  greedy model.
*/

module lz77_tb;

  localparam int WIN_SIZE    = 16;
  localparam int LEN_MAX     = 8;
  localparam int LEN_WD      = $clog2(LEN_MAX + 1);
  localparam int DST_WD      = $clog2(WIN_SIZE + 1);
  localparam int CFG_WD      = lz77_pkg::CFG_LEN_WD;
  localparam int MAX_BYTES   = 64;
  localparam int TOTAL_BYTES = 64 + 32 + 16 + 64;
  localparam int CYCLE_LIMIT = TOTAL_BYTES * (LEN_MAX + 4) + 200;

  logic               clk;
  logic               rstn;
  logic [CFG_WD-1:0]  cfg_len_i;
  logic               start_i;
  logic               done_o;
  logic               rd_val_o;
  lz77_pkg::word_t    rd_dat_i;
  logic               val_o;
  logic               flg_lit_o;
  lz77_pkg::byte_t    dat_lit_o;
  logic [LEN_WD-1:0]  dat_len_o;
  logic [DST_WD-1:0]  dat_dst_o;
  logic               flg_lst_o;

  // job data and expected tokens
  lz77_pkg::byte_t job_bytes [MAX_BYTES];
  bit              exp_lit_a [MAX_BYTES];
  int              exp_len_a [MAX_BYTES];
  int              exp_dst_a [MAX_BYTES];
  lz77_pkg::byte_t exp_byte_a [MAX_BYTES];
  int              job_len;
  int              exp_cnt;
  string           test_name;

  int          rd_ptr;
  int          tok_idx;
  int          len_sum;
  int          match_cnt;
  bit          started;
  int          mism_cnt;
  int          fail_cnt;
  int          cycle_cnt;
  logic [31:0] lcg_state;

  bit              exp_lit_w;
  int              exp_len_w;
  int              exp_dst_w;
  lz77_pkg::byte_t exp_byte_w;
  bit              exp_lst_w;

  `include "lz77_tb_model.svh"

  lz77_top #(
    .WIN_SIZE (WIN_SIZE),
    .LEN_MAX  (LEN_MAX)
  ) i_dut (
    .clk       (clk),
    .rstn      (rstn),
    .cfg_len_i (cfg_len_i),
    .start_i   (start_i),
    .done_o    (done_o),
    .rd_val_o  (rd_val_o),
    .rd_dat_i  (rd_dat_i),
    .val_o     (val_o),
    .flg_lit_o (flg_lit_o),
    .dat_lit_o (dat_lit_o),
    .dat_len_o (dat_len_o),
    .dat_dst_o (dat_dst_o),
    .flg_lst_o (flg_lst_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------
  // FIFO model and token bookkeeping
  // ----------------------------------------
  // one word per strobe, first byte in the top byte
  initial begin
    rd_dat_i = '0;
    rd_ptr   = 0;
    forever begin
      @(posedge clk);
      if (start_i) begin
        rd_ptr = 0;
      end else if (rd_val_o) begin
        rd_dat_i <= {job_bytes[4*rd_ptr], job_bytes[4*rd_ptr+1],
                     job_bytes[4*rd_ptr+2], job_bytes[4*rd_ptr+3]};
        rd_ptr = rd_ptr + 1;
      end
    end
  end

  always @(posedge clk) begin
    if (!rstn || start_i) begin
      started   <= !rstn ? 1'b0 : 1'b1;
      tok_idx   <= 0;
      len_sum   <= 0;
      match_cnt <= 0;
    end else if (val_o) begin
      tok_idx <= tok_idx + 1;
      len_sum <= len_sum + int'(dat_len_o);
      if (!flg_lit_o) begin
        match_cnt <= match_cnt + 1;
      end
    end
  end

  assign exp_lit_w  = (tok_idx < MAX_BYTES) ? exp_lit_a[tok_idx] : 1'b0;
  assign exp_len_w  = (tok_idx < MAX_BYTES) ? exp_len_a[tok_idx] : 0;
  assign exp_dst_w  = (tok_idx < MAX_BYTES) ? exp_dst_a[tok_idx] : 0;
  assign exp_byte_w = (tok_idx < MAX_BYTES) ? exp_byte_a[tok_idx] : '0;
  assign exp_lst_w  = (tok_idx == exp_cnt - 1);

  task automatic report_mismatch(input string what, input int exp_v, input int act_v);
    mism_cnt++;
    $display("Mismatch in %s, %s: expected %0d, actual %0d", test_name, what, exp_v, act_v);
  endtask

  task automatic report_failure(input string msg);
    fail_cnt++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  // ----------------------------------------
  // token checks
  // ----------------------------------------
  a_tok_lit: assert property (@(posedge clk) disable iff (!rstn)
    val_o |-> flg_lit_o == exp_lit_w
  ) else report_mismatch($sformatf("token %0d literal flag", $sampled(tok_idx)),
                         $sampled(exp_lit_w), $sampled(flg_lit_o));

  a_tok_len: assert property (@(posedge clk) disable iff (!rstn)
    val_o |-> int'(dat_len_o) == exp_len_w
  ) else report_mismatch($sformatf("token %0d length", $sampled(tok_idx)),
                         $sampled(exp_len_w), $sampled(dat_len_o));

  a_tok_dst: assert property (@(posedge clk) disable iff (!rstn)
    val_o |-> int'(dat_dst_o) == exp_dst_w
  ) else report_mismatch($sformatf("token %0d distance", $sampled(tok_idx)),
                         $sampled(exp_dst_w), $sampled(dat_dst_o));

  a_tok_byte: assert property (@(posedge clk) disable iff (!rstn)
    (val_o && exp_lit_w) |-> dat_lit_o == exp_byte_w
  ) else report_mismatch($sformatf("token %0d literal byte", $sampled(tok_idx)),
                         $sampled(exp_byte_w), $sampled(dat_lit_o));

  a_tok_lst: assert property (@(posedge clk) disable iff (!rstn)
    val_o |-> flg_lst_o == exp_lst_w
  ) else report_mismatch($sformatf("token %0d last flag", $sampled(tok_idx)),
                         $sampled(exp_lst_w), $sampled(flg_lst_o));

  a_tok_extra: assert property (@(posedge clk) disable iff (!rstn)
    val_o |-> tok_idx < exp_cnt
  ) else report_failure("token output beyond the end of the expected list");

  a_match_shape: assert property (@(posedge clk) disable iff (!rstn)
    (val_o && !flg_lit_o) |-> (dat_dst_o >= dat_len_o) && (dat_len_o <= LEN_MAX)
  ) else report_failure("match token with distance below length or length above maximum");

  // ----------------------------------------
  // job end and idle checks
  // ----------------------------------------
  a_done_follows: assert property (@(posedge clk) disable iff (!rstn)
    (val_o && flg_lst_o) |=> done_o
  ) else report_failure("done_o did not pulse one cycle after the last token");

  a_done_source: assert property (@(posedge clk) disable iff (!rstn)
    done_o |-> $past(val_o && flg_lst_o)
  ) else report_failure("done_o pulsed without a last token one cycle before");

  a_len_sum: assert property (@(posedge clk) disable iff (!rstn)
    done_o |-> len_sum == job_len
  ) else report_mismatch("sum of token lengths", $sampled(job_len), $sampled(len_sum));

  a_tok_total: assert property (@(posedge clk) disable iff (!rstn)
    done_o |-> tok_idx == exp_cnt
  ) else report_mismatch("token count", $sampled(exp_cnt), $sampled(tok_idx));

  a_rd_count: assert property (@(posedge clk) disable iff (!rstn)
    done_o |-> rd_ptr == job_len / 4
  ) else report_mismatch("read strobe count", $sampled(job_len) / 4, $sampled(rd_ptr));

  a_quiet: assert property (@(posedge clk) disable iff (!rstn)
    !started |-> !(rd_val_o || val_o || done_o)
  ) else report_failure("DUT output active after reset before the first start");

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic fill_random(input int n);
    for (int i = 0; i < n; i++) begin
      lcg_state    = lcg_next(lcg_state);
      // four letter alphabet so that runs repeat often
      job_bytes[i] = 8'h61 + 8'(lcg_state[17:16]);
    end
  endtask

  task automatic fill_repeat(input int n);
    for (int i = 0; i < n; i++) begin
      job_bytes[i] = 8'h5a;
    end
  endtask

  task automatic fill_distinct(input int n);
    for (int i = 0; i < n; i++) begin
      job_bytes[i] = 8'(8'h10 + i * 3);
    end
  endtask

  task automatic run_job(input string name, input int n);
    test_name = name;
    job_len   = n;
    exp_cnt   = build_expected(n);
    @(posedge clk);
    cfg_len_i <= CFG_WD'(n);
    start_i   <= 1'b1;
    @(posedge clk);
    start_i   <= 1'b0;
    do begin
      @(posedge clk);
    end while (!done_o);
    @(posedge clk);
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
    fail_cnt++;
    finish_run();
  end

  initial begin
    rstn      = 1'b0;
    start_i   = 1'b0;
    cfg_len_i = '0;
    mism_cnt  = 0;
    fail_cnt  = 0;
    job_len   = 0;
    exp_cnt   = 0;
    test_name = "reset";
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    // idle stretch before the first start
    repeat (5) @(posedge clk);

    lcg_state = 32'd93;
    fill_random(64);
    run_job("random_64", 64);

    // repeat of the first job while its tail still sits in the window
    run_job("random_64_again", 64);

    fill_repeat(32);
    run_job("repeat_32", 32);
    assert (match_cnt > 0) else report_failure("repeated byte run gave no match token");

    fill_distinct(16);
    run_job("distinct_16", 16);
    assert (match_cnt == 0) else report_mismatch("match token count", 0, match_cnt);
    assert (tok_idx == 16) else report_mismatch("literal token count", 16, tok_idx);

    finish_run();
  end

endmodule

`default_nettype wire

// ==== source/lz77_top.sv ====
`timescale 1ns/1ns
`default_nettype none

/*
  LZ77 match finder top level.
  Pulse start_i with the job length on cfg_len_i, a non-zero multiple
  of 4. Words are read from an external FIFO with one cycle latency,
  tokens come out on val_o and done_o follows the last one.
*/

module lz77_top #(
  parameter int WIN_SIZE = 16,
  parameter int LEN_MAX  = 8
) (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic [lz77_pkg::CFG_LEN_WD-1:0] cfg_len_i,
  input  logic                            start_i,
  output logic                            done_o,
  output logic                            rd_val_o,
  input  lz77_pkg::word_t                 rd_dat_i,
  output logic                            val_o,
  output logic                            flg_lit_o,
  output lz77_pkg::byte_t                 dat_lit_o,
  output logic [$clog2(LEN_MAX+1)-1:0]    dat_len_o,
  output logic [$clog2(WIN_SIZE+1)-1:0]   dat_dst_o,
  output logic                            flg_lst_o
);

  logic            push_val;
  lz77_pkg::word_t push_dat;
  logic            all_in;
  logic            job_start;

  lz77_win_if #(
    .WIN_SIZE (WIN_SIZE),
    .LEN_MAX  (LEN_MAX)
  ) i_win_if ();

  // FIFO reads into the buffer
  lz77_fetch #(
    .LEN_MAX (LEN_MAX)
  ) i_fetch (
    .clk         (clk),
    .rstn        (rstn),
    .cfg_len_i   (cfg_len_i),
    .job_start_i (job_start),
    .inp_cnt_i   (i_win_if.inp_cnt),
    .rd_val_o    (rd_val_o),
    .rd_dat_i    (rd_dat_i),
    .push_val_o  (push_val),
    .push_dat_o  (push_dat),
    .all_in_o    (all_in)
  );

  lz77_window #(
    .WIN_SIZE (WIN_SIZE),
    .LEN_MAX  (LEN_MAX)
  ) i_window (
    .clk        (clk),
    .rstn       (rstn),
    .push_val_i (push_val),
    .push_dat_i (push_dat),
    .win        (i_win_if.buf_mp)
  );

  lz77_search #(
    .WIN_SIZE (WIN_SIZE),
    .LEN_MAX  (LEN_MAX)
  ) i_search (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .all_in_i    (all_in),
    .job_start_o (job_start),
    .win         (i_win_if.sch_mp),
    .val_o       (val_o),
    .flg_lit_o   (flg_lit_o),
    .dat_lit_o   (dat_lit_o),
    .dat_len_o   (dat_len_o),
    .dat_dst_o   (dat_dst_o),
    .flg_lst_o   (flg_lst_o),
    .done_o      (done_o)
  );

endmodule

`default_nettype wire

// ==== source/lz77_search.sv ====
`timescale 1ns/1ns
`default_nettype none

/*
  Greedy match search and token output.
  For each token the FSM waits for enough lookahead, then compares
  one lookahead byte per cycle against every window distance at once.
  The nearest surviving distance of the longest run wins. Short runs
  go out as literals. The token is valid one cycle after EMIT, when
  the buffer shift is issued as well.
*/

module lz77_search #(
  parameter int WIN_SIZE = 16,
  parameter int LEN_MAX  = 8
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           start_i,
  input  logic                           all_in_i,
  output logic                           job_start_o,
  lz77_win_if.sch_mp                     win,
  output logic                           val_o,
  output logic                           flg_lit_o,
  output lz77_pkg::byte_t                dat_lit_o,
  output logic [$clog2(LEN_MAX+1)-1:0]   dat_len_o,
  output logic [$clog2(WIN_SIZE+1)-1:0]  dat_dst_o,
  output logic                           flg_lst_o,
  output logic                           done_o
);

  localparam int INP_MAX = LEN_MAX + lz77_pkg::BYTES_PER_WORD;
  localparam int CNT_WD  = $clog2(INP_MAX + 1);
  localparam int LEN_WD  = $clog2(LEN_MAX + 1);
  localparam int DST_WD  = $clog2(WIN_SIZE + 1);

  lz77_pkg::sch_state_t state_r;
  lz77_pkg::sch_state_t state_nxt;

  logic [WIN_SIZE-1:0] flg_r;
  logic [WIN_SIZE-1:0] flg_w;
  logic                any_w;
  logic [DST_WD-1:0]   pick_w;
  logic [LEN_WD-1:0]   step_r;
  logic [LEN_WD-1:0]   cap_w;
  logic [LEN_WD-1:0]   best_len_r;
  logic [DST_WD-1:0]   best_dst_r;
  logic                lit_w;
  logic [LEN_WD-1:0]   tok_len_w;
  logic                last_w;
  logic                ready_w;

  assign job_start_o = (state_r == lz77_pkg::IDLE) && start_i;
  assign win.clear   = job_start_o;

  // ----------------------------------------
  // candidate flags
  // ----------------------------------------
  // bit d-1 stands for distance d
  always_comb begin
    flg_w = '0;
    for (int d = 1; d <= WIN_SIZE; d++) begin
      if (flg_r[d-1] && (d > step_r) && (d <= win.win_cnt)) begin
        flg_w[d-1] = (win.win_dat[d - 1 - step_r] == win.inp_dat[step_r]);
      end
    end
  end

  assign any_w = |flg_w;

  // nearest surviving distance
  always_comb begin
    pick_w = '0;
    for (int d = WIN_SIZE; d >= 1; d--) begin
      if (flg_w[d-1]) begin
        pick_w = DST_WD'(d);
      end
    end
  end

  // run length limited by lookahead and LEN_MAX
  assign cap_w = (win.inp_cnt < CNT_WD'(LEN_MAX)) ? LEN_WD'(win.inp_cnt) : LEN_WD'(LEN_MAX);

  // ----------------------------------------
  // token decision
  // ----------------------------------------
  assign lit_w     = best_len_r < LEN_WD'(lz77_pkg::SIZE_LEN_MIN);
  assign tok_len_w = lit_w ? LEN_WD'(1) : best_len_r;
  assign last_w    = all_in_i && (CNT_WD'(tok_len_w) == win.inp_cnt);

  // a pending shift must land before the next search
  assign ready_w = !val_o && ((win.inp_cnt >= CNT_WD'(LEN_MAX)) ||
                              (all_in_i && (win.inp_cnt != '0)));

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      lz77_pkg::IDLE: begin
        if (start_i) state_nxt = lz77_pkg::WAIT;
      end
      lz77_pkg::WAIT: begin
        if (ready_w) state_nxt = lz77_pkg::SCH;
      end
      lz77_pkg::SCH: begin
        // early end when no candidate is left
        if (!any_w || (step_r + 1'b1 == cap_w)) state_nxt = lz77_pkg::EMIT;
      end
      lz77_pkg::EMIT: begin
        state_nxt = last_w ? lz77_pkg::IDLE : lz77_pkg::WAIT;
      end
      default: state_nxt = lz77_pkg::IDLE;
    endcase
  end

  // ----------------------------------------
  // control registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_r    <= lz77_pkg::IDLE;
      flg_r      <= '0;
      step_r     <= '0;
      best_len_r <= '0;
      val_o      <= 1'b0;
      flg_lst_o  <= 1'b0;
      done_o     <= 1'b0;
    end else begin
      state_r   <= state_nxt;
      val_o     <= (state_r == lz77_pkg::EMIT);
      flg_lst_o <= (state_r == lz77_pkg::EMIT) && last_w;
      done_o    <= val_o && flg_lst_o;
      if (state_r == lz77_pkg::WAIT) begin
        // every distance starts as a candidate
        flg_r      <= '1;
        step_r     <= '0;
        best_len_r <= '0;
      end else if (state_r == lz77_pkg::SCH) begin
        flg_r  <= flg_w;
        step_r <= step_r + 1'b1;
        if (any_w) best_len_r <= step_r + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // token payload
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if ((state_r == lz77_pkg::SCH) && any_w) begin
      best_dst_r <= pick_w;
    end
    if (state_r == lz77_pkg::EMIT) begin
      flg_lit_o <= lit_w;
      dat_lit_o <= win.inp_dat[0];
      dat_len_o <= tok_len_w;
      dat_dst_o <= lit_w ? '0 : best_dst_r;
    end
  end

  // shift goes out together with the token
  assign win.shift_val = val_o;
  assign win.shift_num = dat_len_o;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_len_nonzero: assert property (
    @(posedge clk) disable iff (!rstn)
    val_o |-> dat_len_o >= LEN_WD'(1)
  ) else $error("search: token with zero length");

  a_dst_covers_len: assert property (
    @(posedge clk) disable iff (!rstn)
    (val_o && !flg_lit_o) |-> DST_WD'(dat_len_o) <= dat_dst_o
  ) else $error("search: match source overlaps the lookahead");

endmodule

`default_nettype wire

// ==== source/lz77_window.sv ====
`timescale 1ns/1ns
`default_nettype none

/*
  Byte buffer holding the sliding window and the lookahead.
  Both live in one byte shift register: the window below the
  boundary, the lookahead above it. A shift moves consumed lookahead
  bytes into the window, and a push appends one FIFO word behind the
  valid lookahead. Both may happen in the same cycle.
*/

module lz77_window #(
  parameter int WIN_SIZE = 16,
  parameter int LEN_MAX  = 8
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            push_val_i,
  input  lz77_pkg::word_t push_dat_i,
  lz77_win_if.buf_mp      win
);

  localparam int INP_MAX = LEN_MAX + lz77_pkg::BYTES_PER_WORD;
  localparam int ALL_MAX = WIN_SIZE + INP_MAX;
  localparam int CNT_WD  = $clog2(INP_MAX + 1);
  localparam int WCNT_WD = $clog2(WIN_SIZE + 1);
  localparam int CHN_WD  = lz77_pkg::DATA_CHN_WD;

  // index WIN_SIZE-1 is the nearest window byte, WIN_SIZE the oldest lookahead
  lz77_pkg::byte_t [ALL_MAX-1:0] all_r;
  lz77_pkg::byte_t [ALL_MAX-1:0] all_nxt;

  logic [CNT_WD-1:0]  inp_cnt_r;
  logic [CNT_WD-1:0]  base_w;
  logic [WCNT_WD-1:0] win_cnt_r;
  logic [WCNT_WD:0]   win_sum_w;

  // ----------------------------------------
  // next buffer contents
  // ----------------------------------------
  // lookahead bytes left after this cycle's shift
  always_comb begin
    if (win.clear) begin
      base_w = '0;
    end else if (win.shift_val) begin
      base_w = inp_cnt_r - CNT_WD'(win.shift_num);
    end else begin
      base_w = inp_cnt_r;
    end
  end

  always_comb begin
    all_nxt = all_r;
    if (win.shift_val) begin
      all_nxt = all_r >> (win.shift_num * CHN_WD);
    end
    // new word lands right behind the remaining lookahead
    if (push_val_i) begin
      for (int b = 0; b < lz77_pkg::BYTES_PER_WORD; b++) begin
        all_nxt[WIN_SIZE + base_w + b] =
          push_dat_i[lz77_pkg::DATA_PXL_WD - 1 - b * CHN_WD -: CHN_WD];
      end
    end
  end

  always_ff @(posedge clk) begin
    all_r <= all_nxt;
  end

  // ----------------------------------------
  // fill counts
  // ----------------------------------------
  assign win_sum_w = win_cnt_r + win.shift_num;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      inp_cnt_r <= '0;
      win_cnt_r <= '0;
    end else begin
      inp_cnt_r <= base_w + (push_val_i ? CNT_WD'(lz77_pkg::BYTES_PER_WORD) : '0);
      if (win.clear) begin
        win_cnt_r <= '0;
      end else if (win.shift_val) begin
        // window saturates once full
        if (win_sum_w > WIN_SIZE) begin
          win_cnt_r <= WCNT_WD'(WIN_SIZE);
        end else begin
          win_cnt_r <= win_sum_w[WCNT_WD-1:0];
        end
      end
    end
  end

  // ----------------------------------------
  // views for the search
  // ----------------------------------------
  for (genvar k = 0; k < WIN_SIZE; k++) begin : g_win
    assign win.win_dat[k] = all_r[WIN_SIZE - 1 - k];
  end

  for (genvar j = 0; j < INP_MAX; j++) begin : g_inp
    assign win.inp_dat[j] = all_r[WIN_SIZE + j];
  end

  assign win.win_cnt = win_cnt_r;
  assign win.inp_cnt = inp_cnt_r;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_shift_in_range: assert property (
    @(posedge clk) disable iff (!rstn)
    win.shift_val |-> CNT_WD'(win.shift_num) <= inp_cnt_r
  ) else $error("window: shift of more bytes than the lookahead holds");

  // relies on the read throttle in fetch
  a_inp_bound: assert property (
    @(posedge clk) disable iff (!rstn)
    inp_cnt_r <= CNT_WD'(INP_MAX)
  ) else $error("window: lookahead overflow");

endmodule

`default_nettype wire

// ==== source/lz77_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

/*
  Reads the input stream from the external FIFO.
  A read strobe goes out while words of the job remain and the
  lookahead has room for one more word. The FIFO answers one cycle
  later and the word is pushed into the buffer in that cycle.
  all_in_o rises once the last word of the job has landed.
*/

module lz77_fetch #(
  parameter int LEN_MAX = 8
) (
  input  logic                                                    clk,
  input  logic                                                    rstn,
  input  logic [lz77_pkg::CFG_LEN_WD-1:0]                         cfg_len_i,
  input  logic                                                    job_start_i,
  input  logic [$clog2(LEN_MAX + lz77_pkg::BYTES_PER_WORD + 1)-1:0] inp_cnt_i,
  output logic                                                    rd_val_o,
  input  lz77_pkg::word_t                                         rd_dat_i,
  output logic                                                    push_val_o,
  output lz77_pkg::word_t                                         push_dat_o,
  output logic                                                    all_in_o
);

  localparam int CNT_WD = $clog2(LEN_MAX + lz77_pkg::BYTES_PER_WORD + 1);
  localparam int BPW_SH = $clog2(lz77_pkg::BYTES_PER_WORD);
  localparam int WRD_WD = lz77_pkg::CFG_LEN_WD - BPW_SH;
  localparam int OCC_WD = CNT_WD + 2;

  logic [WRD_WD-1:0] words_left_r;
  logic              active_r;
  logic [OCC_WD-1:0] occ_w;
  logic              rd_go_w;

  // ----------------------------------------
  // read gating
  // ----------------------------------------
  // lookahead bytes plus words already strobed or being pushed
  assign occ_w = OCC_WD'(inp_cnt_i)
               + (rd_val_o   ? OCC_WD'(lz77_pkg::BYTES_PER_WORD) : '0)
               + (push_val_o ? OCC_WD'(lz77_pkg::BYTES_PER_WORD) : '0);

  assign rd_go_w = !job_start_i && (words_left_r != '0) && (occ_w <= OCC_WD'(LEN_MAX));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      words_left_r <= '0;
      active_r     <= 1'b0;
      rd_val_o     <= 1'b0;
      push_val_o   <= 1'b0;
    end else begin
      rd_val_o   <= rd_go_w;
      push_val_o <= rd_val_o;
      if (job_start_i) begin
        words_left_r <= WRD_WD'(cfg_len_i >> BPW_SH);
        active_r     <= 1'b1;
      end else if (rd_go_w) begin
        words_left_r <= words_left_r - 1'b1;
      end
    end
  end

  // FIFO data arrives with the push
  assign push_dat_o = rd_dat_i;

  // nothing left to read and nothing in flight
  assign all_in_o = active_r && (words_left_r == '0) && !rd_val_o && !push_val_o;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_rd_words_left: assert property (
    @(posedge clk) disable iff (!rstn)
    rd_val_o |-> $past(words_left_r) != '0
  ) else $error("fetch: read strobe with no words left");

endmodule

`default_nettype wire

// ==== source/lz77_win_if.sv ====
`timescale 1ns/1ns
`default_nettype none

/*
  Link between the byte buffer and the match search.
  The buffer side publishes the window (nearest byte first), the
  lookahead (oldest byte first) and both fill counts. The search side
  returns the shift command and the clear pulse at job start.
*/

interface lz77_win_if #(
  parameter int WIN_SIZE = 16,
  parameter int LEN_MAX  = 8
);

  localparam int INP_MAX = LEN_MAX + lz77_pkg::BYTES_PER_WORD;
  localparam int CNT_WD  = $clog2(INP_MAX + 1);
  localparam int WCNT_WD = $clog2(WIN_SIZE + 1);
  localparam int LEN_WD  = $clog2(LEN_MAX + 1);

  // buffer contents
  lz77_pkg::byte_t [WIN_SIZE-1:0] win_dat;
  logic [WCNT_WD-1:0]             win_cnt;
  lz77_pkg::byte_t [INP_MAX-1:0]  inp_dat;
  logic [CNT_WD-1:0]              inp_cnt;

  // commands from the search
  logic                           shift_val;
  logic [LEN_WD-1:0]              shift_num;
  logic                           clear;

  modport buf_mp (
    output win_dat, win_cnt, inp_dat, inp_cnt,
    input  shift_val, shift_num, clear
  );

  modport sch_mp (
    input  win_dat, win_cnt, inp_dat, inp_cnt,
    output shift_val, shift_num, clear
  );

endinterface

`default_nettype wire

// ==== source/lz77_pkg.sv ====
`default_nettype none

/*
  Shared constants and types for the LZ77 match finder.
  Byte and word widths, the minimum match length and the width of
  the byte-count configuration live here, next to the search FSM
  state type. Modules refer to them as lz77_pkg::name.
*/

package lz77_pkg;

  // ----------------------------------------
  // data widths
  // ----------------------------------------
  localparam int DATA_CHN_WD    = 8;
  localparam int BYTES_PER_WORD = 4;
  localparam int DATA_PXL_WD    = DATA_CHN_WD * BYTES_PER_WORD;

  // shortest run worth coding as a match
  localparam int SIZE_LEN_MIN   = 3;

  // job length in bytes
  localparam int CFG_LEN_WD     = 16;

  typedef logic [DATA_CHN_WD-1:0] byte_t;

  // first stream byte in the most significant byte
  typedef logic [DATA_PXL_WD-1:0] word_t;

  // ----------------------------------------
  // search FSM
  // ----------------------------------------
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    WAIT = 2'd1,
    SCH  = 2'd2,
    EMIT = 2'd3
  } sch_state_t;

endpackage

`default_nettype wire
